// File: logic/rv_alu_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I integer subset: OP, OP-IMM and LUI only, no CSR or memory
// every other opcode decodes as illegal
//////////////////////////////////////////////////////////////////////
package rv_alu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_form_t;

    typedef struct packed {
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_form_t;

    // one instruction word, three encodings
    typedef union packed {
        logic [31:0] raw;
        r_form_t     r_form;
        i_form_t     i_form;
        u_form_t     u_form;
    } inst_word_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        // clear selects the immediate as operand b
        logic                  use_rs2;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
        logic                  writes_rd;
    } decoded_op_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  illegal;
    } result_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_write_t;

endpackage

// File: logic/reg_file.sv
//////////////////////////////////////////////////////////////////////
// asynchronous reads, x0 is not stored and always reads zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module reg_file (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0] rs2,
    input  rv_alu_pkg::reg_write_t            wr,
    output logic [rv_alu_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_alu_pkg::XLEN-1:0]       rs2_data
);
    import rv_alu_pkg::*;

    // registers 1 to 31 only
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    always_comb begin
        rs1_data = '0;
        if (rs1 != '0) begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        rs2_data = '0;
        if (rs2 != '0) begin
            rs2_data = regs[rs2];
        end
    end

endmodule

// File: logic/inst_decode.sv
//////////////////////////////////////////////////////////////////////
// illegal words leave with rd, rs1 and rs2 cleared
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module inst_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_alu_pkg::inst_word_u  inst,
    input  logic                    inst_valid,
    output logic                    inst_ready,
    output rv_alu_pkg::decoded_op_t dec_op,
    output logic                    dec_valid,
    input  logic                    dec_ready
);
    import rv_alu_pkg::*;

    decoded_op_t dec_next;

    // funct3 mapping shared by register and immediate forms
    function automatic alu_op_e base_op(input logic [2:0] funct3);
        alu_op_e op;
        op = ALU_ADD;
        case (funct3)
            F3_ADD_SUB: op = ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_next = '0;
        dec_next.alu_op = ALU_ADD;
        // opcode sits in the same bits for every form
        case (inst.raw[6:0])
            OPC_OP: begin
                dec_next.rd      = inst.r_form.rd;
                dec_next.rs1     = inst.r_form.rs1;
                dec_next.rs2     = inst.r_form.rs2;
                dec_next.use_rs2 = 1'b1;
                if (inst.r_form.funct7 == F7_BASE) begin
                    dec_next.alu_op = base_op(inst.r_form.funct3);
                end else if (inst.r_form.funct7 == F7_ALT && inst.r_form.funct3 == F3_ADD_SUB) begin
                    dec_next.alu_op = ALU_SUB;
                end else if (inst.r_form.funct7 == F7_ALT && inst.r_form.funct3 == F3_SR) begin
                    dec_next.alu_op = ALU_SRA;
                end else begin
                    dec_next.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec_next.rd     = inst.i_form.rd;
                dec_next.rs1    = inst.i_form.rs1;
                dec_next.imm    = {{(XLEN-12){inst.i_form.imm12[11]}}, inst.i_form.imm12};
                dec_next.alu_op = base_op(inst.i_form.funct3);
                // shifts keep a funct7 code in the top immediate bits
                if (inst.i_form.funct3 == F3_SLL) begin
                    dec_next.illegal = (inst.i_form.imm12[11:5] != F7_BASE);
                end else if (inst.i_form.funct3 == F3_SR) begin
                    if (inst.i_form.imm12[11:5] == F7_ALT) begin
                        dec_next.alu_op = ALU_SRA;
                    end else if (inst.i_form.imm12[11:5] != F7_BASE) begin
                        dec_next.illegal = 1'b1;
                    end
                end
            end
            OPC_LUI: begin
                dec_next.rd     = inst.u_form.rd;
                dec_next.imm    = {inst.u_form.imm20, 12'b0};
                dec_next.alu_op = ALU_PASS_B;
            end
            default: dec_next.illegal = 1'b1;
        endcase
        // no register dependence for an illegal word
        if (dec_next.illegal) begin
            dec_next.rd  = '0;
            dec_next.rs1 = '0;
            dec_next.rs2 = '0;
        end
        dec_next.writes_rd = !dec_next.illegal;
    end

    assign inst_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec_valid <= 1'b0;
        end else if (inst_ready) begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            dec_op <= dec_next;
        end
    end

endmodule

// File: logic/operand_issue.sv
//////////////////////////////////////////////////////////////////////
// forwards the write that is leaving execute in the same cycle
// the issue register holds while exe_ready is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module operand_issue (
    input  logic                        clk,
    input  logic                        rst,
    input  rv_alu_pkg::decoded_op_t     dec_op,
    input  logic                        dec_valid,
    output logic                        dec_ready,
    input  rv_alu_pkg::reg_write_t      wr,
    input  logic                        exe_ready,
    output rv_alu_pkg::decoded_op_t     iss_op,
    output logic [rv_alu_pkg::XLEN-1:0] opa,
    output logic [rv_alu_pkg::XLEN-1:0] opb,
    output logic                        iss_valid
);
    import rv_alu_pkg::*;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] opa_next;
    logic [XLEN-1:0] opb_next;

    reg_file rf_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec_op.rs1),
        .rs2      (dec_op.rs2),
        .wr       (wr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // the register file only sees this write on the next edge
    always_comb begin
        rs1_val = rs1_data;
        rs2_val = rs2_data;
        if (wr.en && wr.addr == dec_op.rs1) begin
            rs1_val = wr.data;
        end
        if (wr.en && wr.addr == dec_op.rs2) begin
            rs2_val = wr.data;
        end
    end

    assign opa_next = rs1_val;
    assign opb_next = dec_op.use_rs2 ? rs2_val : dec_op.imm;

    assign dec_ready = !iss_valid || exe_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            iss_valid <= 1'b0;
        end else if (dec_ready) begin
            iss_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            iss_op <= dec_op;
            opa    <= opa_next;
            opb    <= opb_next;
        end
    end

endmodule

// File: logic/alu_execute.sv
//////////////////////////////////////////////////////////////////////
// purely combinational, shifts use the low SHAMT_W bits of b
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module alu_execute (
    input  rv_alu_pkg::decoded_op_t     iss_op,
    input  logic [rv_alu_pkg::XLEN-1:0] opa,
    input  logic [rv_alu_pkg::XLEN-1:0] opb,
    input  logic                        iss_valid,
    output rv_alu_pkg::result_t         exe_result,
    output logic                        exe_valid
);
    import rv_alu_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [XLEN-1:0]    alu_out;

    assign shamt       = opb[SHAMT_W-1:0];
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        alu_out = '0;
        case (iss_op.alu_op)
            ALU_ADD:    alu_out = opa + opb;
            ALU_SUB:    alu_out = opa - opb;
            ALU_SLL:    alu_out = opa << shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    alu_out = opa ^ opb;
            ALU_SRL:    alu_out = opa >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(opa) >>> shamt);
            ALU_OR:     alu_out = opa | opb;
            ALU_AND:    alu_out = opa & opb;
            // lui carries its value in the immediate
            ALU_PASS_B: alu_out = opb;
            default:    alu_out = '0;
        endcase
    end

    // illegal ops report zero data
    always_comb begin
        exe_result.rd      = iss_op.rd;
        exe_result.illegal = iss_op.illegal;
        exe_result.data    = iss_op.writes_rd ? alu_out : '0;
    end

    assign exe_valid = iss_valid;

endmodule

// File: logic/result_stage.sv
//////////////////////////////////////////////////////////////////////
// wr is live in the cycle a result loads, never for x0 or illegal
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module result_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_alu_pkg::result_t    exe_result,
    input  logic                   exe_valid,
    output logic                   exe_ready,
    output rv_alu_pkg::reg_write_t wr,
    output rv_alu_pkg::result_t    result,
    output logic                   result_valid,
    input  logic                   result_ready
);
    import rv_alu_pkg::*;

    logic load;

    assign exe_ready = !result_valid || result_ready;
    assign load      = exe_valid && exe_ready;

    // register write on the same edge as the output register
    always_comb begin
        wr.en   = load && !exe_result.illegal && exe_result.rd != '0;
        wr.addr = exe_result.rd;
        wr.data = exe_result.data;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result_valid <= 1'b0;
        end else if (exe_ready) begin
            result_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= exe_result;
        end
    end

endmodule

// File: logic/alu_pipeline.sv
//////////////////////////////////////////////////////////////////////
// three stages, result two edges after acceptance without stalls
// both streams use valid/ready, results stay in order
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module alu_pipeline (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_alu_pkg::inst_word_u inst,
    input  logic                   inst_valid,
    output logic                   inst_ready,
    output rv_alu_pkg::result_t    result,
    output logic                   result_valid,
    input  logic                   result_ready
);
    import rv_alu_pkg::*;

    decoded_op_t     dec_op;
    logic            dec_valid;
    logic            dec_ready;
    decoded_op_t     iss_op;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            iss_valid;
    result_t         exe_result;
    logic            exe_valid;
    logic            exe_ready;
    reg_write_t      wr;

    inst_decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .dec_op     (dec_op),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready)
    );

    operand_issue issue_i (
        .clk       (clk),
        .rst       (rst),
        .dec_op    (dec_op),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .wr        (wr),
        .exe_ready (exe_ready),
        .iss_op    (iss_op),
        .opa       (opa),
        .opb       (opb),
        .iss_valid (iss_valid)
    );

    alu_execute execute_i (
        .iss_op     (iss_op),
        .opa        (opa),
        .opb        (opb),
        .iss_valid  (iss_valid),
        .exe_result (exe_result),
        .exe_valid  (exe_valid)
    );

    result_stage result_i (
        .clk          (clk),
        .rst          (rst),
        .exe_result   (exe_result),
        .exe_valid    (exe_valid),
        .exe_ready    (exe_ready),
        .wr           (wr),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

// File: tests/alu_ref_model.svh
//////////////////////////////////////////////////////////////////////
// ISA model of the OP, OP-IMM and LUI subset, x0 stays zero
// included inside alu_pipeline_tb, needs lfsr_bits from there
//////////////////////////////////////////////////////////////////////
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

logic [31:0] model_regs [0:31];

function automatic void model_clear();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

// expected record for one accepted word, updates the model registers
function automatic result_t model_step(input inst_word_u inst);
    result_t     res;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        legal;
    logic        alt;
    rd = inst.raw[11:7];
    f3 = inst.raw[14:12];
    f7 = inst.raw[31:25];
    a = model_regs[inst.raw[19:15]];
    b = model_regs[inst.raw[24:20]];
    alt = 1'b0;
    legal = 1'b1;
    val = '0;
    case (inst.raw[6:0])
        OPC_OP: begin
            alt = (f7 == 7'b0100000);
            legal = (f7 == 7'b0000000) || (alt && (f3 == 3'b000 || f3 == 3'b101));
        end
        OPC_OP_IMM: begin
            b = {{20{inst.raw[31]}}, inst.raw[31:20]};
            // only the shifts keep a funct7 code in the immediate
            if (f3 == 3'b001) begin
                legal = (f7 == 7'b0000000);
            end else if (f3 == 3'b101) begin
                alt = (f7 == 7'b0100000);
                legal = (f7 == 7'b0000000) || alt;
            end
        end
        OPC_LUI: legal = 1'b1;
        default: legal = 1'b0;
    endcase
    case (f3)
        3'b000: val = alt ? a - b : a + b;
        3'b001: val = a << b[4:0];
        3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: val = (a < b) ? 32'd1 : 32'd0;
        3'b100: val = a ^ b;
        3'b101: begin
            if (alt) begin
                val = $unsigned($signed(a) >>> b[4:0]);
            end else begin
                val = a >> b[4:0];
            end
        end
        3'b110: val = a | b;
        default: val = a & b;
    endcase
    if (inst.raw[6:0] == OPC_LUI) begin
        val = {inst.raw[31:12], 12'b0};
    end
    res.illegal = !legal;
    res.rd = legal ? rd : 5'd0;
    res.data = legal ? val : 32'd0;
    if (legal && rd != 5'd0) begin
        model_regs[rd] = val;
    end
    return res;
endfunction

// registers x0 to x3 only, so dependences come often
function automatic inst_word_u random_inst();
    inst_word_u  w;
    logic [31:0] r;
    logic [31:0] imm;
    logic [3:0]  kind;
    logic        alt;
    r = lfsr_bits(14);
    imm = lfsr_bits(25);
    kind = r[3:0];
    alt = r[13];
    w.raw = '0;
    if (kind < 4'd6 || kind == 4'd14) begin
        w.r_form.opcode = OPC_OP;
        w.r_form.rd = {3'b0, r[8:7]};
        w.r_form.funct3 = r[6:4];
        w.r_form.rs1 = {3'b0, r[10:9]};
        w.r_form.rs2 = {3'b0, r[12:11]};
        w.r_form.funct7 = F7_BASE;
        if (alt && (r[6:4] == F3_ADD_SUB || r[6:4] == F3_SR)) begin
            w.r_form.funct7 = F7_ALT;
        end
        // kind 14 is a funct7 that no instruction uses
        if (kind == 4'd14) begin
            w.r_form.funct7 = imm[6:0] | 7'b0000001;
        end
    end else if (kind < 4'd11 || kind == 4'd15) begin
        w.i_form.opcode = OPC_OP_IMM;
        w.i_form.rd = {3'b0, r[8:7]};
        w.i_form.funct3 = r[6:4];
        w.i_form.rs1 = {3'b0, r[10:9]};
        w.i_form.imm12 = imm[11:0];
        if (kind == 4'd15) begin
            w.i_form.funct3 = alt ? F3_SR : F3_SLL;
            w.i_form.imm12[11:5] = imm[11:5] | 7'b0000010;
        end else if (r[6:4] == F3_SLL) begin
            w.i_form.imm12[11:5] = F7_BASE;
        end else if (r[6:4] == F3_SR) begin
            w.i_form.imm12[11:5] = alt ? F7_ALT : F7_BASE;
        end
    end else if (kind < 4'd13) begin
        w.u_form.opcode = OPC_LUI;
        w.u_form.rd = {3'b0, r[8:7]};
        w.u_form.imm20 = imm[19:0];
    end else begin
        // load or branch opcode, neither is supported
        w.raw = {imm[24:0], alt ? 7'b0000011 : 7'b1100011};
    end
    return w;
endfunction

`endif

// File: tests/alu_pipeline_tb.sv
//////////////////////////////////////////////////////////////////////
// random OP, OP-IMM and LUI stream with result back-pressure
// latency is checked only while result_ready is held high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module alu_pipeline_tb;
    import rv_alu_pkg::*;

    localparam int N_DIRECTED = 6;
    localparam int N_STREAM   = 200;
    localparam int N_STALL    = 400;
    localparam int N_TOTAL    = N_DIRECTED + N_STREAM + N_STALL;
    localparam int CLK_PERIOD = 4;

    logic        clk;
    logic        rst;
    inst_word_u  inst;
    logic        inst_valid;
    logic        inst_ready;
    result_t     result;
    logic        result_valid;
    logic        result_ready;

    logic [31:0] lfsr_state = 32'h70143e09;
    result_t     exp_q[$];
    int          edge_q[$];
    int          idx_q[$];
    int          edge_cnt = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          checked = 0;
    logic        stall_phase = 1'b0;
    logic        stalled_prev = 1'b0;
    result_t     held;

    alu_pipeline dut_i (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    // galois lfsr, one step per returned bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    `include "alu_ref_model.svh"

    function automatic string test_name(input int idx);
        if (idx < N_DIRECTED) begin
            return $sformatf("directed %0d", idx);
        end
        if (idx < N_DIRECTED + N_STREAM) begin
            return $sformatf("stream %0d", idx - N_DIRECTED);
        end
        return $sformatf("stall %0d", idx - N_DIRECTED - N_STREAM);
    endfunction

    task automatic check_result(input string name, input result_t exp, input result_t act);
        checked++;
        if (act.illegal !== 1'b0 || act.rd !== exp.rd || act.data !== exp.data) begin
            $display("error %s: expected rd x%0d data %h, actual rd x%0d data %h illegal %b",
                     name, exp.rd, exp.data, act.rd, act.data, act.illegal);
            value_errors++;
        end
    endtask

    task automatic check_illegal(input string name, input result_t act);
        checked++;
        if (act.illegal !== 1'b1 || act.data !== '0) begin
            $display("error %s: expected illegal 1 data %h, actual illegal %b data %h",
                     name, 32'h0, act.illegal, act.data);
            value_errors++;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        if (stall_phase) begin
            r = lfsr_bits(2);
            result_ready = (r[1:0] != 2'b00);
        end
    endtask

    task automatic send(input inst_word_u word, input int idx);
        logic        accepted;
        logic [31:0] r;
        if (stall_phase) begin
            r = lfsr_bits(2);
            if (r[1:0] == 2'b00) begin
                inst_valid = 1'b0;
                next_cycle();
            end
        end
        inst = word;
        inst_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = inst_ready;
            if (accepted) begin
                exp_q.push_back(model_step(word));
                edge_q.push_back(edge_cnt + 1);
                idx_q.push_back(idx);
            end
            next_cycle();
        end
        inst_valid = 1'b0;
    endtask

    // keeps toggling result_ready in the stall phase until all results are out
    task automatic drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
    end

    // scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin : compare
        result_t exp_res;
        int      idx;
        if (rst) begin
            if (stalled_prev && !result_valid) begin
                $display("result_valid dropped while result_ready was low");
                other_errors++;
            end else if (stalled_prev && result !== held) begin
                $display("result changed while stalled, %h became %h", held, result);
                other_errors++;
            end
            if (!stall_phase && result_valid && !stalled_prev && exp_q.size() != 0) begin
                if (edge_cnt - edge_q[0] != 2) begin
                    $display("%s arrived %0d edges after acceptance instead of 2",
                             test_name(idx_q[0]), edge_cnt - edge_q[0]);
                    other_errors++;
                end
            end
            if (result_valid && result_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a result was sent with no instruction pending");
                    other_errors++;
                end else begin
                    exp_res = exp_q.pop_front();
                    idx = idx_q.pop_front();
                    void'(edge_q.pop_front());
                    if (exp_res.illegal) begin
                        check_illegal(test_name(idx), result);
                    end else begin
                        check_result(test_name(idx), exp_res, result);
                    end
                end
            end
            stalled_prev = result_valid && !result_ready;
            held = result;
        end
    end

    initial begin : driver
        logic [31:0] directed [N_DIRECTED];
        inst_word_u  word;
        // x0 write, reads after reset, lui then a forwarded use, srai
        directed[0] = 32'h7ff00013;
        directed[1] = 32'h000000b3;
        directed[2] = 32'h0030e133;
        directed[3] = 32'habcde1b7;
        directed[4] = 32'h003180b3;
        directed[5] = 32'h4040d113;
        inst = '0;
        inst_valid = 1'b0;
        result_ready = 1'b1;
        rst = 1'b0;
        model_clear();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        if (inst_ready !== 1'b1 || result_valid !== 1'b0) begin
            $display("after reset inst_ready is %b and result_valid is %b",
                     inst_ready, result_valid);
            other_errors++;
        end
        next_cycle();
        for (int i = 0; i < N_DIRECTED; i++) begin
            word.raw = directed[i];
            send(word, i);
        end
        for (int i = 0; i < N_STREAM; i++) begin
            send(random_inst(), N_DIRECTED + i);
        end
        drain();
        stall_phase = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            send(random_inst(), N_DIRECTED + N_STREAM + i);
        end
        drain();
        stall_phase = 1'b0;
        result_ready = 1'b1;
        repeat (4) next_cycle();
        @(negedge clk);
        if (result_valid !== 1'b0) begin
            $display("result_valid is still high after every result was taken");
            other_errors++;
        end
        if (checked != N_TOTAL) begin
            $display("only %0d of %0d results were checked", checked, N_TOTAL);
            other_errors++;
        end
        $display("errors: %0d value, %0d other, %0d results checked",
                 value_errors, other_errors, checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // four cycles per instruction is well above the worst stall rate
    initial begin
        #((N_TOTAL * 4 + 200) * CLK_PERIOD);
        $display("timeout: the pipeline did not return all results in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: build.f
+incdir+tests
logic/rv_alu_pkg.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/operand_issue.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/alu_pipeline.sv
tests/alu_pipeline_tb.sv
